/* Bender.yml */
package:
  name: cache_sys

sources:
  - source/cache_cfg_pkg.sv
  - source/mem_bus_pkg.sv
  - source/sync_ram.sv
  - source/fetch_cache.sv
  - source/data_port.sv
  - source/mem_arbiter.sv
  - source/cache_sys_top.sv
  - target: simulation
    files:
      - sim/mem_arbiter_sva.sv
      - sim/cache_sys_tb.sv

/* cache_sys_top.f */
source/cache_cfg_pkg.sv
source/mem_bus_pkg.sv
source/sync_ram.sv
source/fetch_cache.sv
source/data_port.sv
source/mem_arbiter.sv
source/cache_sys_top.sv
sim/mem_arbiter_sva.sv
sim/cache_sys_tb.sv

/* sim/cache_sys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sys_tb;

    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int TMO = 200;

    logic     clk = 1'b0;
    logic     i_arst_n;
    logic     i_fetch_req;
    addr_t    i_fetch_addr;
    logic     o_fetch_busy;
    logic     o_fetch_valid;
    word_t    o_fetch_data;
    logic     i_data_req;
    mem_req_t i_data_cmd;
    logic     o_data_busy;
    mem_rsp_t o_data_rsp;
    mem_req_t o_mem_req;
    mem_rsp_t i_mem_rsp;

    line_t    mem_q   [addr_t];                         // Only lines that were written.
    int       rd_cnt  [addr_t];
    addr_t    log_q   [$];
    addr_t    exp_log [$];
    mem_req_t cur_req;
    logic     mem_busy;
    int       mem_wait;
    int       val_errs   = 0;
    int       other_errs = 0;

    always #4 clk = ~clk;

    cache_sys_top DUT (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_busy  (o_fetch_busy),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .i_data_req    (i_data_req),
        .i_data_cmd    (i_data_cmd),
        .o_data_busy   (o_data_busy),
        .o_data_rsp    (o_data_rsp),
        .o_mem_req     (o_mem_req),
        .i_mem_rsp     (i_mem_rsp)
    );

    ////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////

    function automatic line_t mem_line(input addr_t a);
        if (mem_q.exists(a)) begin
            return mem_q[a];
        end
        return {a ^ 32'h5A5A_A5A5, ~a};                 // Unwritten lines follow the address.
    endfunction

    function automatic word_t exp_word(input addr_t a);
        line_t l;
        l = mem_line({a[ADDR_W-1:3], 3'b000});
        return a[2] ? l[63:32] : l[31:0];
    endfunction

    function automatic int reads_of(input addr_t a);
        return rd_cnt.exists(a) ? rd_cnt[a] : 0;
    endfunction

    initial begin
        void'($urandom(85));
        i_mem_rsp = '0;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        cur_req   = '0;
        forever begin
            @(negedge clk);
            if (!i_arst_n) begin
                i_mem_rsp = '0;
                mem_busy  = 1'b0;
            end else begin
                if (i_mem_rsp.valid) begin                // The pulse lasts one cycle.
                    i_mem_rsp = '0;
                    mem_busy  = 1'b0;
                end
                if (mem_busy) begin
                    mem_wait--;
                    if (mem_wait == 0) begin
                        if (cur_req.wr) begin
                            i_mem_rsp.rdata     = mem_line(cur_req.addr);  // Not zero on a write.
                            mem_q[cur_req.addr] = cur_req.wdata;
                        end else begin
                            i_mem_rsp.rdata = mem_line(cur_req.addr);
                        end
                        i_mem_rsp.valid = 1'b1;
                    end
                end else if (o_mem_req.rd || o_mem_req.wr) begin
                    cur_req  = o_mem_req;
                    mem_busy = 1'b1;
                    mem_wait = 1 + ($urandom % 4);        // Answer after 1 to 4 cycles.
                    log_q.push_back(o_mem_req.addr);
                    if (o_mem_req.rd) begin
                        rd_cnt[o_mem_req.addr] = reads_of(o_mem_req.addr) + 1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
        end
    endtask

    task automatic check_log(input string what);
        if (log_q.size() != exp_log.size()) begin
            other_errs++;
            $display("%s: memory saw %0d transactions where %0d were expected",
                     what, log_q.size(), exp_log.size());
        end else begin
            foreach (exp_log[i]) begin
                check_addr("o_mem_req.addr", log_q[i], exp_log[i]);
            end
        end
        log_q.delete();
        exp_log.delete();
    endtask

    task automatic check_reads(input addr_t a, input int n);
        if (reads_of(a) != n) begin
            other_errs++;
            $display("Line at %h was read %0d times instead of %0d", a, reads_of(a), n);
        end
    endtask

    ////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////

    task automatic fetch(input addr_t a, output word_t data, output int lat);
        @(negedge clk);
        i_fetch_req  = 1'b1;
        i_fetch_addr = a;
        lat          = 0;
        do begin
            @(negedge clk);
            i_fetch_req = 1'b0;
            lat++;
        end while (!o_fetch_valid && lat < TMO);
        if (!o_fetch_valid) begin
            other_errs++;
            $display("Fetch of %h never returned a word", a);
        end
        data = o_fetch_data;
    endtask

    task automatic data_op(input logic wr, input addr_t a, input line_t d, output line_t rdata);
        int n;
        @(negedge clk);
        i_data_req       = 1'b1;
        i_data_cmd       = '0;
        i_data_cmd.rd    = !wr;
        i_data_cmd.wr    = wr;
        i_data_cmd.addr  = a;
        i_data_cmd.wdata = d;
        n                = 0;
        do begin
            @(negedge clk);
            i_data_req = 1'b0;
            n++;
        end while (!o_data_rsp.valid && n < TMO);
        if (!o_data_rsp.valid) begin
            other_errs++;
            $display("Data port request to %h never got a response", a);
        end
        rdata = o_data_rsp.rdata;
    endtask

    ////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////

    task automatic test_reset_and_cold();
        word_t w;
        int    lat;
        if (o_fetch_busy || o_fetch_valid || o_data_busy || o_data_rsp.valid ||
            o_mem_req.rd || o_mem_req.wr) begin
            other_errs++;
            $display("A busy, valid or memory request bit is set after reset");
        end
        fetch(32'h0000_0104, w, lat);
        check_word("o_fetch_data", w, exp_word(32'h0000_0104));
        exp_log.push_back(32'h0000_0100);
        check_log("cold fetch");
        check_reads(32'h0000_0100, 1);
    endtask

    task automatic test_hits();
        addr_t seq [2] = '{32'h0000_0104, 32'h0000_0100};
        word_t w;
        int    lat;
        foreach (seq[i]) begin
            fetch(seq[i], w, lat);
            check_word("o_fetch_data", w, exp_word(seq[i]));
            if (lat != 3) begin
                other_errs++;
                $display("Hit on %h took %0d cycles instead of 3", seq[i], lat);
            end
        end
        check_log("hits");
    endtask

    // Set 5, tags 8, 16 and 24. Ages pick way 1 twice, so the first tag stays.
    task automatic test_replacement();
        addr_t seq [7] = '{32'h1028, 32'h2028, 32'h102C, 32'h3028,
                           32'h1028, 32'h202C, 32'h1028};
        word_t w;
        int    lat;
        foreach (seq[i]) begin
            fetch(seq[i], w, lat);
            check_word("o_fetch_data", w, exp_word(seq[i]));
        end
        exp_log.push_back(32'h2028);
        exp_log.push_front(32'h1028);
        exp_log.push_back(32'h3028);
        exp_log.push_back(32'h2028);
        check_log("replacement");
        check_reads(32'h1028, 1);
        check_reads(32'h2028, 2);
        check_reads(32'h3028, 1);
    endtask

    task automatic test_data_port();
        line_t wline = 64'h0123_4567_89AB_CDEF;
        line_t l;
        word_t w;
        int    lat;
        data_op(1'b1, 32'h4010, wline, l);
        check_line("o_data_rsp.rdata", l, '0);
        data_op(1'b0, 32'h4010, '0, l);
        check_line("o_data_rsp.rdata", l, wline);
        fetch(32'h4014, w, lat);
        check_word("o_fetch_data", w, wline[63:32]);
        repeat (3) exp_log.push_back(32'h4010);
        check_log("data port");
    endtask

    task automatic concurrent_round(input addr_t fa, input addr_t da);
        word_t w;
        line_t l;
        int    lat;
        fork
            fetch(fa, w, lat);
            begin
                repeat (2) @(negedge clk);              // Both requests reach the bus together.
                data_op(1'b0, da, '0, l);
            end
        join
        check_word("o_fetch_data", w, exp_word(fa));
        check_line("o_data_rsp.rdata", l, mem_line(da));
        exp_log.push_back(da);                          // The fetch was served last.
        exp_log.push_back({fa[ADDR_W-1:3], 3'b000});
    endtask

    initial begin
        i_arst_n     = 1'b0;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_data_req   = 1'b0;
        i_data_cmd   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);

        test_reset_and_cold();
        test_hits();
        test_replacement();
        test_data_port();
        concurrent_round(32'h5008, 32'h6000);
        concurrent_round(32'h7010, 32'h6008);
        check_log("shared bus");
        repeat (4) @(negedge clk);

        $display("Errors: %0d value, %0d other, %0d assertion",
                 val_errs, other_errs, DUT.u_mem_arbiter.u_arb_sva.fail_cnt);
        if (val_errs + other_errs + DUT.u_mem_arbiter.u_arb_sva.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mem_arbiter_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_sva #(
    parameter int N_REQ = mem_bus_pkg::N_REQ
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  mem_bus_pkg::mem_req_t i_req [N_REQ],
    input  mem_bus_pkg::mem_rsp_t o_rsp [N_REQ],
    input  mem_bus_pkg::mem_req_t o_mem_req,
    input  mem_bus_pkg::mem_rsp_t i_mem_rsp
);

    logic [N_REQ-1:0] rsp_vld;
    logic [N_REQ-1:0] req_act;
    int               fail_cnt = 0;                    // Read by the testbench.

    always_comb begin
        for (int i = 0; i < N_REQ; i++) begin
            rsp_vld[i] = o_rsp[i].valid;
            req_act[i] = i_req[i].rd || i_req[i].wr;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (o_mem_req.rd || o_mem_req.wr) && !i_mem_rsp.valid |=> $stable(o_mem_req))
        else begin
            $error("Memory request changed before its response");
            fail_cnt++;
        end

    // A response reaches one requester at most, and only one that is asking.
    a_one_rsp: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(rsp_vld) && ((rsp_vld & ~req_act) == '0))
        else begin
            $error("A response went to more than one requester or to an idle one");
            fail_cnt++;
        end

    a_rd_wr: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(o_mem_req.rd && o_mem_req.wr))
        else begin
            $error("Memory request has rd and wr set together");
            fail_cnt++;
        end

endmodule

bind mem_arbiter mem_arbiter_sva #(.N_REQ(N_REQ)) u_arb_sva (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_req     (i_req),
    .o_rsp     (o_rsp),
    .o_mem_req (o_mem_req),
    .i_mem_rsp (i_mem_rsp)
);

`default_nettype wire

/* source/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

    ////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////

    parameter int ADDR_W = 32;
    parameter int SETS   = 64;
    parameter int LINE_W = 64;
    parameter int WORD_W = 32;
    parameter int AGE_W  = 3;

    // Address split: [ADDR_W-1:9] tag, [8:3] index, [2] word select.
    parameter int IDX_W   = 6;
    parameter int IDX_LSB = 3;
    parameter int TAG_LSB = IDX_LSB + IDX_W;
    parameter int TAG_W   = ADDR_W - TAG_LSB;

    ////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        tag_t tag;                                      // Valid bit is kept in flops.
    } tag_entry_t;

endpackage

`default_nettype wire

/* source/cache_sys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sys_top #(
    parameter int SETS   = cache_cfg_pkg::SETS,
    parameter int ADDR_W = cache_cfg_pkg::ADDR_W,
    parameter int N_REQ  = mem_bus_pkg::N_REQ
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_fetch_req,
    input  cache_cfg_pkg::addr_t  i_fetch_addr,
    output logic                  o_fetch_busy,
    output logic                  o_fetch_valid,
    output cache_cfg_pkg::word_t  o_fetch_data,
    input  logic                  i_data_req,
    input  mem_bus_pkg::mem_req_t i_data_cmd,
    output logic                  o_data_busy,
    output mem_bus_pkg::mem_rsp_t o_data_rsp,
    output mem_bus_pkg::mem_req_t o_mem_req,
    input  mem_bus_pkg::mem_rsp_t i_mem_rsp
);

    import mem_bus_pkg::*;

    mem_req_t arb_req [N_REQ];                          // 0 fetch, 1 data port.
    mem_rsp_t arb_rsp [N_REQ];

    fetch_cache #(.SETS(SETS), .ADDR_W(ADDR_W)) u_fetch_cache (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_busy  (o_fetch_busy),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .o_mem_req     (arb_req[0]),
        .i_mem_rsp     (arb_rsp[0])
    );

    data_port u_data_port (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_data_req  (i_data_req),
        .i_data_cmd  (i_data_cmd),
        .o_data_busy (o_data_busy),
        .o_data_rsp  (o_data_rsp),
        .o_mem_req   (arb_req[1]),
        .i_mem_rsp   (arb_rsp[1])
    );

    mem_arbiter #(.N_REQ(N_REQ)) u_mem_arbiter (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_req     (arb_req),
        .o_rsp     (arb_rsp),
        .o_mem_req (o_mem_req),
        .i_mem_rsp (i_mem_rsp)
    );

endmodule

`default_nettype wire

/* source/data_port.sv */
`timescale 1ns/1ps
`default_nettype none

module data_port (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_data_req,
    input  mem_bus_pkg::mem_req_t i_data_cmd,
    output logic                  o_data_busy,
    output mem_bus_pkg::mem_rsp_t o_data_rsp,
    output mem_bus_pkg::mem_req_t o_mem_req,
    input  mem_bus_pkg::mem_rsp_t i_mem_rsp
);

    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    mem_req_t cmd_q;
    line_t    rdata_q;
    logic     pend_q;                                   // Memory transaction open.
    logic     rsp_vld_q;
    logic     accept;
    logic     done;

    // A command with neither rd nor wr is dropped.
    assign accept = i_data_req && !o_data_busy && (i_data_cmd.rd || i_data_cmd.wr);
    assign done   = pend_q && i_mem_rsp.valid;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_q    <= 1'b0;
            rsp_vld_q <= 1'b0;
        end else begin
            rsp_vld_q <= done;
            if (accept) begin
                pend_q <= 1'b1;
            end else if (done) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= i_data_cmd;
        end
        if (done) begin
            rdata_q <= cmd_q.wr ? '0 : i_mem_rsp.rdata;  // Writes answer with zero.
        end
    end

    always_comb begin
        o_mem_req    = cmd_q;
        o_mem_req.rd = pend_q && cmd_q.rd;
        o_mem_req.wr = pend_q && cmd_q.wr;
    end

    assign o_data_busy      = pend_q || rsp_vld_q;
    assign o_data_rsp.valid = rsp_vld_q;
    assign o_data_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* source/fetch_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_cache #(
    parameter int SETS   = cache_cfg_pkg::SETS,
    parameter int ADDR_W = cache_cfg_pkg::ADDR_W
) (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_fetch_req,
    input  cache_cfg_pkg::addr_t    i_fetch_addr,
    output logic                    o_fetch_busy,
    output logic                    o_fetch_valid,
    output cache_cfg_pkg::word_t    o_fetch_data,
    output mem_bus_pkg::mem_req_t   o_mem_req,
    input  mem_bus_pkg::mem_rsp_t   i_mem_rsp
);

    import cache_cfg_pkg::*;

    localparam int WAYS = 2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_HIT,
        S_MISS
    } state_t;

    state_t     state_q;
    logic       rd_done_q;                              // RAM output valid in READ.
    addr_t      addr_q;
    index_t     idx;
    tag_t       tag_q;
    word_t      data_q;
    logic       accept;
    logic       fill;
    logic       hit_clr;
    logic       victim;
    logic       hit_way;
    logic [1:0] hit;
    logic [1:0] way_we;
    line_t      hit_line;
    tag_entry_t tag_wr;
    tag_entry_t tag_rd  [WAYS];
    line_t      line_rd [WAYS];

    logic [SETS-1:0]  valid_q [WAYS];
    logic [AGE_W-1:0] age_q   [WAYS][SETS];

    assign idx         = addr_q[8:3];
    assign tag_q       = addr_q[ADDR_W-1:9];
    assign tag_wr.tag  = tag_q;
    assign accept      = (state_q == S_IDLE) && i_fetch_req;
    assign fill        = (state_q == S_MISS) && i_mem_rsp.valid;
    assign hit_clr     = (state_q == S_READ) && rd_done_q && (|hit);

    ////////////////////////////////////////////////////
    // Tag and line RAMs
    ////////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        sync_ram #(.DEPTH(SETS), .T(tag_entry_t)) u_tag_ram (
            .clk     (clk),
            .i_addr  (idx),
            .i_we    (way_we[w]),
            .i_wdata (tag_wr),
            .o_rdata (tag_rd[w])
        );

        sync_ram #(.DEPTH(SETS), .T(line_t)) u_line_ram (
            .clk     (clk),
            .i_addr  (idx),
            .i_we    (way_we[w]),
            .i_wdata (i_mem_rsp.rdata),
            .o_rdata (line_rd[w])
        );

        assign hit[w]    = valid_q[w][idx] && (tag_rd[w].tag == tag_q);
        assign way_we[w] = fill && (victim == 1'(w));
    end

    assign hit_way  = hit[1] && !hit[0];                // Way 0 wins if both match.
    assign hit_line = line_rd[hit_way];

    // Invalid way first, then the older one; a tie goes to way 0.
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim = 1'b1;
        end else begin
            victim = (age_q[0][idx] >= age_q[1][idx]) ? 1'b0 : 1'b1;
        end
    end

    ////////////////////////////////////////////////////
    // Lookup FSM
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= S_IDLE;
            rd_done_q <= 1'b0;
        end else begin
            rd_done_q <= (state_q == S_READ) && !rd_done_q;
            case (state_q)
                S_IDLE: if (i_fetch_req) state_q <= S_READ;
                S_READ: begin
                    if (rd_done_q) begin
                        state_q <= (|hit) ? S_HIT : S_MISS;
                    end
                end
                S_HIT:  state_q <= S_IDLE;
                S_MISS: if (i_mem_rsp.valid) state_q <= S_READ;   // Look up again.
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_fetch_addr;
        end
        if (hit_clr) begin
            data_q <= addr_q[2] ? hit_line[63:32] : hit_line[31:0];
        end
    end

    ////////////////////////////////////////////////////
    // Valid bits and age counters
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
                for (int s = 0; s < SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            if (accept) begin
                for (int w = 0; w < WAYS; w++) begin
                    for (int s = 0; s < SETS; s++) begin
                        if (age_q[w][s] != {AGE_W{1'b1}}) begin
                            age_q[w][s] <= age_q[w][s] + 1'b1;
                        end
                    end
                end
            end
            if (hit_clr) begin
                age_q[hit_way][idx] <= '0;
            end
            if (fill) begin
                valid_q[victim][idx] <= 1'b1;
                age_q[victim][idx]   <= '0;
            end
        end
    end

    assign o_fetch_busy  = (state_q != S_IDLE);
    assign o_fetch_valid = (state_q == S_HIT);
    assign o_fetch_data  = data_q;

    always_comb begin
        o_mem_req      = '0;
        o_mem_req.rd   = (state_q == S_MISS);           // Held until the response.
        o_mem_req.addr = {addr_q[ADDR_W-1:3], 3'b000};
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int N_REQ = mem_bus_pkg::N_REQ
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  mem_bus_pkg::mem_req_t i_req [N_REQ],
    output mem_bus_pkg::mem_rsp_t o_rsp [N_REQ],
    output mem_bus_pkg::mem_req_t o_mem_req,
    input  mem_bus_pkg::mem_rsp_t i_mem_rsp
);

    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [N_REQ-1:0] act;
    logic [IDX_W-1:0] last_q;                           // Last requester served.
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] pick;
    logic [IDX_W-1:0] grant;
    logic             lock_q;
    logic             pick_vld;
    logic             gnt_vld;

    always_comb begin
        for (int i = 0; i < N_REQ; i++) begin
            act[i] = i_req[i].rd || i_req[i].wr;
        end
    end

    // Search starts one past the last served requester.
    always_comb begin
        int unsigned cand;
        pick     = last_q;
        pick_vld = 1'b0;
        for (int k = 1; k <= N_REQ; k++) begin
            cand = (int'(last_q) + k) % N_REQ;
            if (!pick_vld && act[cand]) begin
                pick     = cand[IDX_W-1:0];
                pick_vld = 1'b1;
            end
        end
    end

    assign grant   = lock_q ? grant_q : pick;
    assign gnt_vld = lock_q || pick_vld;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lock_q  <= 1'b0;
            grant_q <= '0;
            last_q  <= IDX_W'(N_REQ - 1);               // Requester 0 goes first.
        end else if (gnt_vld && i_mem_rsp.valid) begin
            lock_q <= 1'b0;
            last_q <= grant;
        end else if (!lock_q && pick_vld) begin
            lock_q  <= 1'b1;
            grant_q <= pick;
        end
    end

    always_comb begin
        o_mem_req = '0;
        if (gnt_vld) begin
            o_mem_req = i_req[grant];
        end
        for (int i = 0; i < N_REQ; i++) begin
            o_rsp[i].valid = gnt_vld && i_mem_rsp.valid && (grant == IDX_W'(i));
            o_rsp[i].rdata = i_mem_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

/* source/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Requester 0 is the fetch cache, requester 1 the data port.
    parameter int N_REQ = 2;

    ////////////////////////////////////////////////////
    // Shared memory bus
    ////////////////////////////////////////////////////

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        cache_cfg_pkg::addr_t addr;                     // Always 8-byte aligned.
        cache_cfg_pkg::line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;                    // One-cycle pulse.
        cache_cfg_pkg::line_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* source/sync_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter int  DEPTH = 64,
    parameter type T     = logic
) (
    input  logic                  clk,
    input  cache_cfg_pkg::index_t i_addr,
    input  logic                  i_we,
    input  T                      i_wdata,
    output T                      o_rdata
);

    T mem [DEPTH];

    // Read returns the old entry when a write hits the same address.
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];                         // One cycle read latency.
    end

endmodule

`default_nettype wire
